//--- hdl/axil_ctrl_port.sv
`timescale 1ns/1ps
`default_nettype none

module axil_ctrl_port (
    input  wire                                   clk,
    input  wire                                   arst_n,

    // AXI4-Lite slave
    input  wire  [soc_ctrl_pkg::ADDR_W - 1:0]     awaddr,
    input  wire                                   awvalid,
    output logic                                  awready,
    input  wire  soc_ctrl_pkg::data_t             wdata,
    input  wire  soc_ctrl_pkg::strb_t             wstrb,
    input  wire                                   wvalid,
    output logic                                  wready,
    output soc_ctrl_pkg::resp_t                   bresp,
    output logic                                  bvalid,
    input  wire                                   bready,
    input  wire  [soc_ctrl_pkg::ADDR_W - 1:0]     araddr,
    input  wire                                   arvalid,
    output logic                                  arready,
    output soc_ctrl_pkg::data_t                   rdata,
    output soc_ctrl_pkg::resp_t                   rresp,
    output logic                                  rvalid,
    input  wire                                   rready,

    // target access
    output logic                                  cfg_sel,
    output logic                                  intc_sel,
    output logic                                  acc_write,
    output soc_ctrl_pkg::off_t                    acc_off,
    output soc_ctrl_pkg::strb_t                   acc_strb,
    output soc_ctrl_pkg::data_t                   acc_wdata,
    input  wire  soc_ctrl_pkg::data_t             cfg_rdata,
    input  wire                                   cfg_err,
    input  wire  soc_ctrl_pkg::data_t             intc_rdata,
    input  wire                                   intc_err
);

typedef enum logic [1:0] {
    ST_IDLE,
    ST_ACCESS,
    ST_RESP
} state_t;

state_t                state;

logic                  aw_hs;
logic                  ar_hs;
logic                  resp_hs;

logic                  req_write;
logic                  req_tsel;
soc_ctrl_pkg::off_t    req_off;
soc_ctrl_pkg::strb_t   req_strb;
soc_ctrl_pkg::data_t   req_wdata;

soc_ctrl_pkg::data_t   resp_data;
soc_ctrl_pkg::resp_t   resp_code;
logic                  tgt_err;

// read has priority over a simultaneous write
assign arready = (state == ST_IDLE) && arvalid;
assign awready = (state == ST_IDLE) && awvalid && wvalid && !arvalid;
assign wready  = awready;

assign ar_hs   = arvalid && arready;
assign aw_hs   = awvalid && awready;
assign resp_hs = (bvalid && bready) || (rvalid && rready);

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        state     <= ST_IDLE;
        req_write <= 1'b0;
    end else begin
        case (state)
            ST_IDLE: begin
                if (ar_hs) begin
                    state     <= ST_ACCESS;
                    req_write <= 1'b0;
                end else if (aw_hs) begin
                    state     <= ST_ACCESS;
                    req_write <= 1'b1;
                end
            end
            // one select cycle, then respond
            ST_ACCESS: begin
                state <= ST_RESP;
            end
            ST_RESP: begin
                if (resp_hs) begin
                    state <= ST_IDLE;
                end
            end
            default: begin
                state <= ST_IDLE;
            end
        endcase
    end
end

// request payload
always_ff @(posedge clk) begin
    if (ar_hs) begin
        req_tsel <= araddr[soc_ctrl_pkg::TARGET_SEL_BIT];
        req_off  <= araddr[soc_ctrl_pkg::OFF_W - 1:0];
        req_strb <= '0;
    end else if (aw_hs) begin
        req_tsel  <= awaddr[soc_ctrl_pkg::TARGET_SEL_BIT];
        req_off   <= awaddr[soc_ctrl_pkg::OFF_W - 1:0];
        req_strb  <= wstrb;
        req_wdata <= wdata;
    end
end

assign cfg_sel   = (state == ST_ACCESS) && !req_tsel;
assign intc_sel  = (state == ST_ACCESS) && req_tsel;
assign acc_write = req_write;
assign acc_off   = req_off;
assign acc_strb  = req_strb;
assign acc_wdata = req_wdata;

assign tgt_err   = req_tsel ? intc_err : cfg_err;

// response captured at the end of the select cycle, held until taken
always_ff @(posedge clk) begin
    if (state == ST_ACCESS) begin
        resp_data <= req_tsel ? intc_rdata : cfg_rdata;
        resp_code <= tgt_err ? soc_ctrl_pkg::RESP_SLVERR : soc_ctrl_pkg::RESP_OKAY;
    end
end

assign bvalid = (state == ST_RESP) && req_write;
assign rvalid = (state == ST_RESP) && !req_write;
assign bresp  = resp_code;
assign rresp  = resp_code;
assign rdata  = resp_data;

endmodule

`default_nettype wire

//--- hdl/cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

module cfg_regs (
    input  wire                         clk,
    input  wire                         arst_n,

    input  wire                         sel,
    input  wire                         acc_write,
    input  wire  soc_ctrl_pkg::off_t    acc_off,
    input  wire  soc_ctrl_pkg::strb_t   acc_strb,
    input  wire  soc_ctrl_pkg::data_t   acc_wdata,
    output soc_ctrl_pkg::data_t         rdata,
    output logic                        err,

    output soc_ctrl_pkg::data_t         core_bootvec,
    output logic                        core_rstn
);

soc_ctrl_pkg::data_t   bootvec;
logic                  run;
soc_ctrl_pkg::data_t   wmask;
logic                  wr_en;

assign wmask = soc_ctrl_pkg::strb_mask(acc_strb);
assign wr_en = sel && acc_write && !err;

// read decode, unmapped offsets flag an error
always_comb begin
    rdata = '0;
    err   = 1'b0;
    case (acc_off)
        soc_ctrl_pkg::CFG_BOOTVEC_OFF: rdata = bootvec;
        soc_ctrl_pkg::CFG_CTRL_OFF:    rdata = {31'b0, run};
        default:                       err   = 1'b1;
    endcase
end

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        bootvec <= soc_ctrl_pkg::BOOTVEC_RESET;
        run     <= 1'b0;
    end else if (wr_en) begin
        if (acc_off == soc_ctrl_pkg::CFG_BOOTVEC_OFF) begin
            bootvec <= (bootvec & ~wmask) | (acc_wdata & wmask);
        end
        // run lives in the low byte
        if (acc_off == soc_ctrl_pkg::CFG_CTRL_OFF && acc_strb[0]) begin
            run <= acc_wdata[0];
        end
    end
end

assign core_bootvec = bootvec;

// run clears asynchronously with arst_n, so the core is held in reset then too
assign core_rstn = run;

endmodule

`default_nettype wire

//--- hdl/intc_regs.sv
`timescale 1ns/1ps
`default_nettype none

module intc_regs (
    input  wire                                  clk,
    input  wire                                  arst_n,

    input  wire                                  sel,
    input  wire                                  acc_write,
    input  wire  soc_ctrl_pkg::off_t             acc_off,
    input  wire  soc_ctrl_pkg::strb_t            acc_strb,
    input  wire  soc_ctrl_pkg::data_t            acc_wdata,
    output soc_ctrl_pkg::data_t                  rdata,
    output logic                                 err,

    input  wire  [soc_ctrl_pkg::NUM_IRQ - 1:0]   irq_src,
    output logic                                 msip,
    output logic                                 mtip,
    output logic                                 meip
);

logic                                 msip_q;
soc_ctrl_pkg::data_t                  mtime;
soc_ctrl_pkg::data_t                  mtimecmp;
logic [soc_ctrl_pkg::NUM_IRQ - 1:0]   pend;
logic [soc_ctrl_pkg::NUM_IRQ - 1:0]   en;
logic [soc_ctrl_pkg::NUM_IRQ - 1:0]   irq_q;
logic [soc_ctrl_pkg::NUM_IRQ - 1:0]   irq_rise;
logic [soc_ctrl_pkg::NUM_IRQ - 1:0]   pend_clr;

soc_ctrl_pkg::data_t                  wmask;
soc_ctrl_pkg::data_t                  wbits;
logic                                 wr_en;

assign wmask = soc_ctrl_pkg::strb_mask(acc_strb);
assign wbits = acc_wdata & wmask;
assign wr_en = sel && acc_write && !err;

always_comb begin
    rdata = '0;
    err   = 1'b0;
    case (acc_off)
        soc_ctrl_pkg::INTC_MSIP_OFF:     rdata = {31'b0, msip_q};
        soc_ctrl_pkg::INTC_MTIME_OFF:    rdata = mtime;
        soc_ctrl_pkg::INTC_MTIMECMP_OFF: rdata = mtimecmp;
        soc_ctrl_pkg::INTC_PEND_OFF:     rdata = soc_ctrl_pkg::data_t'(pend);
        soc_ctrl_pkg::INTC_EN_OFF:       rdata = soc_ctrl_pkg::data_t'(en);
        default:                         err   = 1'b1;
    endcase
end

// software interrupt and enables
always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        msip_q   <= 1'b0;
        en       <= '0;
        mtimecmp <= soc_ctrl_pkg::MTIMECMP_RESET;
    end else if (wr_en) begin
        if (acc_off == soc_ctrl_pkg::INTC_MSIP_OFF && acc_strb[0]) begin
            msip_q <= acc_wdata[0];
        end
        if (acc_off == soc_ctrl_pkg::INTC_EN_OFF) begin
            en <= (en & ~wmask[soc_ctrl_pkg::NUM_IRQ - 1:0]) |
                  wbits[soc_ctrl_pkg::NUM_IRQ - 1:0];
        end
        if (acc_off == soc_ctrl_pkg::INTC_MTIMECMP_OFF) begin
            mtimecmp <= (mtimecmp & ~wmask) | wbits;
        end
    end
end

// free running timer, a write replaces the increment for that cycle
always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        mtime <= '0;
    end else if (wr_en && acc_off == soc_ctrl_pkg::INTC_MTIME_OFF) begin
        mtime <= (mtime & ~wmask) | wbits;
    end else begin
        mtime <= mtime + 1'b1;
    end
end

assign mtip = (mtime >= mtimecmp);

// edge latch for external sources
assign irq_rise = irq_src & ~irq_q;
assign pend_clr = (wr_en && acc_off == soc_ctrl_pkg::INTC_PEND_OFF) ?
                  wbits[soc_ctrl_pkg::NUM_IRQ - 1:0] : '0;

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        irq_q <= '0;
        pend  <= '0;
    end else begin
        irq_q <= irq_src;
        // a new edge beats a clear in the same cycle
        pend  <= (pend & ~pend_clr) | irq_rise;
    end
end

assign meip = |(pend & en);
assign msip = msip_q;

endmodule

`default_nettype wire

//--- hdl/soc_ctrl_pkg.sv
`default_nettype none

package soc_ctrl_pkg;

// bus geometry
localparam int ADDR_W         = 32;
localparam int DATA_W         = 32;
localparam int STRB_W         = DATA_W / 8;
localparam int OFF_W          = 5;

// address bit 27 set selects the interrupt controller
localparam int TARGET_SEL_BIT = 27;
localparam int NUM_IRQ        = 8;

typedef logic [DATA_W - 1:0] data_t;
typedef logic [STRB_W - 1:0] strb_t;
typedef logic [ OFF_W - 1:0] off_t;
typedef logic [         1:0] resp_t;

localparam resp_t RESP_OKAY         = 2'd0;
localparam resp_t RESP_SLVERR       = 2'd2;

// configuration block map
localparam off_t  CFG_BOOTVEC_OFF   = 5'h00;
localparam off_t  CFG_CTRL_OFF      = 5'h04;

// interrupt controller map
localparam off_t  INTC_MSIP_OFF     = 5'h00;
localparam off_t  INTC_MTIME_OFF    = 5'h04;
localparam off_t  INTC_MTIMECMP_OFF = 5'h08;
localparam off_t  INTC_PEND_OFF     = 5'h0c;
localparam off_t  INTC_EN_OFF       = 5'h10;

localparam data_t BOOTVEC_RESET     = 32'h8000_0000;
localparam data_t MTIMECMP_RESET    = '1;

// expand byte strobes into a bit mask
function automatic data_t strb_mask(input strb_t strb);
    data_t mask;
    for (int i = 0; i < STRB_W; i++) begin
        mask[8 * i +: 8] = {8{strb[i]}};
    end
    return mask;
endfunction

endpackage

`default_nettype wire

//--- hdl/soc_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module soc_ctrl_top (
    input  wire                                  clk,
    input  wire                                  arst_n,

    // AXI4-Lite slave
    input  wire  [soc_ctrl_pkg::ADDR_W - 1:0]    awaddr,
    input  wire                                  awvalid,
    output logic                                 awready,
    input  wire  soc_ctrl_pkg::data_t            wdata,
    input  wire  soc_ctrl_pkg::strb_t            wstrb,
    input  wire                                  wvalid,
    output logic                                 wready,
    output soc_ctrl_pkg::resp_t                  bresp,
    output logic                                 bvalid,
    input  wire                                  bready,
    input  wire  [soc_ctrl_pkg::ADDR_W - 1:0]    araddr,
    input  wire                                  arvalid,
    output logic                                 arready,
    output soc_ctrl_pkg::data_t                  rdata,
    output soc_ctrl_pkg::resp_t                  rresp,
    output logic                                 rvalid,
    input  wire                                  rready,

    // interrupt sources and core control
    input  wire  [soc_ctrl_pkg::NUM_IRQ - 1:0]   irq_src,
    output logic                                 core_rstn,
    output soc_ctrl_pkg::data_t                  core_bootvec,
    output logic                                 msip,
    output logic                                 mtip,
    output logic                                 meip
);

logic                  cfg_sel;
logic                  intc_sel;
logic                  acc_write;
soc_ctrl_pkg::off_t    acc_off;
soc_ctrl_pkg::strb_t   acc_strb;
soc_ctrl_pkg::data_t   acc_wdata;
soc_ctrl_pkg::data_t   cfg_rdata;
logic                  cfg_err;
soc_ctrl_pkg::data_t   intc_rdata;
logic                  intc_err;

axil_ctrl_port u_port (
    .clk        ( clk        ),
    .arst_n     ( arst_n     ),
    .awaddr     ( awaddr     ),
    .awvalid    ( awvalid    ),
    .awready    ( awready    ),
    .wdata      ( wdata      ),
    .wstrb      ( wstrb      ),
    .wvalid     ( wvalid     ),
    .wready     ( wready     ),
    .bresp      ( bresp      ),
    .bvalid     ( bvalid     ),
    .bready     ( bready     ),
    .araddr     ( araddr     ),
    .arvalid    ( arvalid    ),
    .arready    ( arready    ),
    .rdata      ( rdata      ),
    .rresp      ( rresp      ),
    .rvalid     ( rvalid     ),
    .rready     ( rready     ),
    .cfg_sel    ( cfg_sel    ),
    .intc_sel   ( intc_sel   ),
    .acc_write  ( acc_write  ),
    .acc_off    ( acc_off    ),
    .acc_strb   ( acc_strb   ),
    .acc_wdata  ( acc_wdata  ),
    .cfg_rdata  ( cfg_rdata  ),
    .cfg_err    ( cfg_err    ),
    .intc_rdata ( intc_rdata ),
    .intc_err   ( intc_err   )
);

cfg_regs u_cfg_regs (
    .clk          ( clk          ),
    .arst_n       ( arst_n       ),
    .sel          ( cfg_sel      ),
    .acc_write    ( acc_write    ),
    .acc_off      ( acc_off      ),
    .acc_strb     ( acc_strb     ),
    .acc_wdata    ( acc_wdata    ),
    .rdata        ( cfg_rdata    ),
    .err          ( cfg_err      ),
    .core_bootvec ( core_bootvec ),
    .core_rstn    ( core_rstn    )
);

intc_regs u_intc_regs (
    .clk       ( clk        ),
    .arst_n    ( arst_n     ),
    .sel       ( intc_sel   ),
    .acc_write ( acc_write  ),
    .acc_off   ( acc_off    ),
    .acc_strb  ( acc_strb   ),
    .acc_wdata ( acc_wdata  ),
    .rdata     ( intc_rdata ),
    .err       ( intc_err   ),
    .irq_src   ( irq_src    ),
    .msip      ( msip       ),
    .mtip      ( mtip       ),
    .meip      ( meip       )
);

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, then scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -f verilog.f --top-module tb_soc_ctrl > sim.log 2>&1 \
    && ./obj_dir/Vtb_soc_ctrl >> sim.log 2>&1 \
    || echo "Test failures found" >> sim.log
cat sim.log
if grep -q "Test failures found" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
echo "simulation passed"
exit 0

//--- tb/soc_ctrl_cases.txt
// columns: op addr data strb expected resp (hex); op 1 write, 2 read, 3 set irq_src,
// op 4 check outputs (data is core_bootvec, expected is core_rstn meip mtip msip), op 0 ends
4 00000000 80000000 0 0        0
2 00000000 00000000 0 80000000 0
2 00000004 00000000 0 00000000 0
1 00000000 12345678 3 00000000 0
2 00000000 00000000 0 80005678 0
1 00000000 abcdef00 c 00000000 0
2 00000000 00000000 0 abcd5678 0
4 00000000 abcd5678 0 0        0
1 00000004 00000001 1 00000000 0
2 00000004 00000000 0 00000001 0
4 00000000 abcd5678 0 8        0
1 08000000 00000001 1 00000000 0
2 08000000 00000000 0 00000001 0
4 00000000 abcd5678 0 9        0
1 08000000 00000000 1 00000000 0
4 00000000 abcd5678 0 8        0
1 08000008 00000000 f 00000000 0
2 08000008 00000000 0 00000000 0
4 00000000 abcd5678 0 a        0
1 08000008 ffffffff f 00000000 0
4 00000000 abcd5678 0 8        0
3 00000000 00000005 0 00000000 0
2 0800000c 00000000 0 00000005 0
4 00000000 abcd5678 0 8        0
1 08000010 00000004 1 00000000 0
4 00000000 abcd5678 0 c        0
1 0800000c 00000004 1 00000000 0
2 0800000c 00000000 0 00000001 0
4 00000000 abcd5678 0 8        0
3 00000000 00000000 0 00000000 0
2 00000008 00000000 0 00000000 2
1 00000008 ffffffff f 00000000 2
2 08000014 00000000 0 00000000 2
1 08000014 ffffffff f 00000000 2
2 00000000 00000000 0 abcd5678 0
2 00000004 00000000 0 00000001 0
2 08000010 00000000 0 00000004 0
2 0800000c 00000000 0 00000001 0
4 00000000 abcd5678 0 8        0
0 00000000 00000000 0 00000000 0

//--- tb/tb_soc_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_soc_ctrl;

localparam int MAX_CASES = 64;
localparam int TIMEOUT   = 50;

logic          clk;
logic          arst_n;
logic [31:0]   awaddr;
logic          awvalid;
logic          awready;
logic [31:0]   wdata;
logic [3:0]    wstrb;
logic          wvalid;
logic          wready;
logic [1:0]    bresp;
logic          bvalid;
logic          bready;
logic [31:0]   araddr;
logic          arvalid;
logic          arready;
logic [31:0]   rdata;
logic [1:0]    rresp;
logic          rvalid;
logic          rready;
logic [7:0]    irq_src;
logic          core_rstn;
logic [31:0]   core_bootvec;
logic          msip;
logic          mtip;
logic          meip;

// six words per case: op, addr, data, strb, expected, response
logic [31:0]   case_mem [0:6 * MAX_CASES - 1];
logic [31:0]   rnd_state;
int            error_count;
int            case_errors;
int            case_total;
int            case_failed;
bit            timed_out;

soc_ctrl_top uut (
    .clk          ( clk          ),
    .arst_n       ( arst_n       ),
    .awaddr       ( awaddr       ),
    .awvalid      ( awvalid      ),
    .awready      ( awready      ),
    .wdata        ( wdata        ),
    .wstrb        ( wstrb        ),
    .wvalid       ( wvalid       ),
    .wready       ( wready       ),
    .bresp        ( bresp        ),
    .bvalid       ( bvalid       ),
    .bready       ( bready       ),
    .araddr       ( araddr       ),
    .arvalid      ( arvalid      ),
    .arready      ( arready      ),
    .rdata        ( rdata        ),
    .rresp        ( rresp        ),
    .rvalid       ( rvalid       ),
    .rready       ( rready       ),
    .irq_src      ( irq_src      ),
    .core_rstn    ( core_rstn    ),
    .core_bootvec ( core_bootvec ),
    .msip         ( msip         ),
    .mtip         ( mtip         ),
    .meip         ( meip         )
);

initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
end

function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
        $display("MISMATCH time=%0t %s got=%h expected=%h", $time, name, got, exp);
        error_count++;
        case_errors++;
    end
endtask

task automatic report_timeout(input string what);
    $display("ERROR time=%0t timed out waiting for %s", $time, what);
    error_count++;
    case_errors++;
    timed_out = 1'b1;
endtask

// pending response must not move, and nothing new may be accepted
task automatic check_response_held(input bit is_read, input logic [31:0] data,
                                   input logic [1:0] resp);
    check_value(is_read ? "rvalid" : "bvalid", 32'(is_read ? rvalid : bvalid), 32'd1);
    check_value(is_read ? "rresp" : "bresp", 32'(is_read ? rresp : bresp), 32'(resp));
    if (is_read) begin
        check_value("rdata", rdata, data);
    end
    check_value("awready", 32'(awready), 32'd0);
    check_value("wready", 32'(wready), 32'd0);
    check_value("arready", 32'(arready), 32'd0);
endtask

// request valids are up; the transfer happens on the edge after ready is seen
task automatic wait_accept(input bit is_read, output bit ok);
    int cnt;
    cnt = 0;
    ok  = 1'b0;
    while (!ok && cnt < TIMEOUT) begin
        @(negedge clk);
        cnt++;
        ok = is_read ? arready : (awready && wready);
    end
    if (!ok) begin
        report_timeout(is_read ? "arready" : "awready and wready");
    end
    @(posedge clk);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    arvalid <= 1'b0;
endtask

// finish the read that was offered while a response was pending
task automatic take_early_read();
    bit ok;
    bit got;
    int cnt;
    wait_accept(1'b1, ok);
    got = 1'b0;
    cnt = 0;
    while (ok && !got && cnt < TIMEOUT) begin
        @(negedge clk);
        cnt++;
        got = rvalid;
    end
    if (ok && !got) begin
        report_timeout("rvalid of the early read");
    end
    if (got) begin
        @(posedge clk);
        rready <= 1'b1;
        @(posedge clk);
        rready <= 1'b0;
    end
endtask

task automatic wait_response(input bit is_read, output bit got,
                             output logic [31:0] data, output logic [1:0] resp);
    int lat;
    int hold;
    lat  = 0;
    got  = 1'b0;
    data = '0;
    resp = '0;
    while (!got && lat < TIMEOUT) begin
        @(negedge clk);
        lat++;
        got = is_read ? rvalid : bvalid;
    end
    if (!got) begin
        report_timeout(is_read ? "rvalid" : "bvalid");
    end else begin
        check_value("response latency", lat, 32'd2);
        data      = rdata;
        resp      = is_read ? rresp : bresp;
        rnd_state = xorshift(rnd_state);
        hold      = int'(rnd_state & 32'h3);
        // an early read must stall behind the pending response
        @(posedge clk);
        arvalid <= 1'b1;
        for (int i = 0; i < hold; i++) begin
            @(negedge clk);
            check_response_held(is_read, data, resp);
        end
        @(posedge clk);
        if (is_read) begin
            rready <= 1'b1;
        end else begin
            bready <= 1'b1;
        end
        @(negedge clk);
        check_response_held(is_read, data, resp);
        @(posedge clk);
        bready <= 1'b0;
        rready <= 1'b0;
        take_early_read();
    end
endtask

task automatic run_write(input logic [31:0] addr, input logic [31:0] data,
                         input logic [31:0] strb, input logic [31:0] exp_resp);
    bit          ok;
    bit          got;
    logic [31:0] rd;
    logic [1:0]  rs;
    @(posedge clk);
    awaddr  <= addr;
    awvalid <= 1'b1;
    wdata   <= data;
    wstrb   <= strb[3:0];
    wvalid  <= 1'b1;
    wait_accept(1'b0, ok);
    if (ok) begin
        wait_response(1'b0, got, rd, rs);
        if (got) begin
            check_value("bresp", 32'(rs), exp_resp);
        end
    end
endtask

task automatic run_read(input logic [31:0] addr, input logic [31:0] exp_data,
                        input logic [31:0] exp_resp);
    bit          ok;
    bit          got;
    logic [31:0] rd;
    logic [1:0]  rs;
    @(posedge clk);
    araddr  <= addr;
    arvalid <= 1'b1;
    wait_accept(1'b1, ok);
    if (ok) begin
        wait_response(1'b1, got, rd, rs);
        if (got) begin
            check_value("rdata", rd, exp_data);
            check_value("rresp", 32'(rs), exp_resp);
        end
    end
endtask

// one edge to sample the new level, one more for the pending bit
task automatic drive_irq(input logic [31:0] value);
    @(posedge clk);
    irq_src <= value[7:0];
    repeat (2) @(posedge clk);
endtask

// flags: bit 3 core_rstn, bit 2 meip, bit 1 mtip, bit 0 msip
task automatic check_outputs(input logic [31:0] bootvec, input logic [31:0] flags);
    @(negedge clk);
    check_value("core_bootvec", core_bootvec, bootvec);
    check_value("core_rstn", 32'(core_rstn), 32'(flags[3]));
    check_value("meip", 32'(meip), 32'(flags[2]));
    check_value("mtip", 32'(mtip), 32'(flags[1]));
    check_value("msip", 32'(msip), 32'(flags[0]));
endtask

initial begin
    int          idx;
    logic [31:0] op;
    arst_n      = 1'b0;
    awaddr      = '0;
    awvalid     = 1'b0;
    wdata       = '0;
    wstrb       = '0;
    wvalid      = 1'b0;
    bready      = 1'b0;
    araddr      = '0;
    arvalid     = 1'b0;
    rready      = 1'b0;
    irq_src     = '0;
    rnd_state   = 32'h3c72_08ba;
    error_count = 0;
    case_errors = 0;
    case_total  = 0;
    case_failed = 0;
    timed_out   = 1'b0;
    for (int k = 0; k < 6 * MAX_CASES; k++) begin
        case_mem[k] = '0;
    end
    $readmemh("tb/soc_ctrl_cases.txt", case_mem);

    repeat (2) @(posedge clk);
    arst_n <= 1'b1;
    @(posedge clk);

    // op 0 ends the list
    idx = 0;
    while (idx < MAX_CASES && case_mem[6 * idx] != '0 && !timed_out) begin
        case_errors = 0;
        op = case_mem[6 * idx];
        case (op)
            32'd1: run_write(case_mem[6 * idx + 1], case_mem[6 * idx + 2],
                             case_mem[6 * idx + 3], case_mem[6 * idx + 5]);
            32'd2: run_read(case_mem[6 * idx + 1], case_mem[6 * idx + 4],
                            case_mem[6 * idx + 5]);
            32'd3: drive_irq(case_mem[6 * idx + 2]);
            32'd4: check_outputs(case_mem[6 * idx + 2], case_mem[6 * idx + 4]);
            default: begin
                $display("ERROR unknown op %h in case %0d", op, idx);
                error_count++;
                case_errors++;
            end
        endcase
        if (case_errors == 0) begin
            $display("case %0d op %0d ok", idx, op);
        end else begin
            $display("case %0d op %0d failed", idx, op);
            case_failed++;
        end
        case_total++;
        idx++;
    end
    if (case_total == 0) begin
        $display("ERROR no cases were read from the case file");
        error_count++;
    end

    $display("summary: %0d cases run, %0d failed, %0d errors", case_total, case_failed,
             error_count);
    if (error_count == 0) begin
        $display("All tests passed!");
    end else begin
        $display("Test failures found");
    end
    $finish;
end

endmodule

`default_nettype wire

//--- verilog.f
hdl/soc_ctrl_pkg.sv
hdl/axil_ctrl_port.sv
hdl/cfg_regs.sv
hdl/intc_regs.sv
hdl/soc_ctrl_top.sv
tb/tb_soc_ctrl.sv
